// ==== files.f ====
+incdir+verilog
+incdir+dv
verilog/decode_pkg.sv
verilog/sb_if.sv
verilog/inst_fields.sv
verilog/reg_file.sv
verilog/scoreboard.sv
verilog/issue_ctrl.sv
verilog/decode_top.sv
dv/decode_tb.sv

// ==== run.sh ====
#!/bin/bash
# Builds and runs the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module decode_tb -f files.f -o decode_tb \
    && ./obj_dir/decode_tb \
    || exit 1

// ==== dv/decode_tb_table.svh ====
`ifndef DECODE_TB_TABLE_SVH
`define DECODE_TB_TABLE_SVH

// Columns: instruction word, row kind, expected exec_op, exec_alt, exec_rd
localparam int NUM_ROWS = 24;
row_t rows [NUM_ROWS];

task automatic fill_table();
    // First run, reads of never written registers come first
    rows[0]  = '{enc_r(7'h00, 5'd1, 5'd2, 3'd0, 5'd3), ROW_ALU, 3'd0, 1'b0, 5'd3};
    rows[1]  = '{enc_u(20'h12345, 5'd1), ROW_ALU, 3'd0, 1'b0, 5'd1};
    rows[2]  = '{enc_i(12'hff9, 5'd0, 3'd0, 5'd2), ROW_ALU, 3'd0, 1'b0, 5'd2};
    rows[3]  = '{enc_i(12'h678, 5'd1, 3'd0, 5'd1), ROW_ALU, 3'd0, 1'b0, 5'd1};
    // Dependent chain
    rows[4]  = '{enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd4), ROW_ALU, 3'd0, 1'b0, 5'd4};
    rows[5]  = '{enc_r(7'h20, 5'd1, 5'd4, 3'd0, 5'd5), ROW_ALU, 3'd0, 1'b1, 5'd5};
    rows[6]  = '{enc_r(7'h00, 5'd4, 5'd5, 3'd4, 5'd6), ROW_ALU, 3'd4, 1'b0, 5'd6};
    rows[7]  = '{enc_i(12'h402, 5'd6, 3'd5, 5'd7), ROW_ALU, 3'd5, 1'b1, 5'd7};
    rows[8]  = '{enc_r(7'h20, 5'd2, 5'd7, 3'd5, 5'd8), ROW_ALU, 3'd5, 1'b1, 5'd8};
    rows[9]  = '{enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd9), ROW_ALU, 3'd2, 1'b0, 5'd9};
    rows[10] = '{enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd10), ROW_ALU, 3'd3, 1'b0, 5'd10};
    rows[11] = '{enc_i(12'h004, 5'd1, 3'd1, 5'd11), ROW_ALU, 3'd1, 1'b0, 5'd11};
    rows[12] = '{enc_i(12'h003, 5'd2, 3'd5, 5'd12), ROW_ALU, 3'd5, 1'b0, 5'd12};
    rows[13] = '{enc_i(12'h0f0, 5'd2, 3'd7, 5'd13), ROW_ALU, 3'd7, 1'b0, 5'd13};
    rows[14] = '{enc_i(12'hf00, 5'd1, 3'd6, 5'd14), ROW_ALU, 3'd6, 1'b0, 5'd14};
    rows[15] = '{enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0), ROW_ALU, 3'd0, 1'b0, 5'd0};  // rd x0
    rows[16] = '{enc_r(7'h00, 5'd13, 5'd14, 3'd6, 5'd15), ROW_ALU, 3'd6, 1'b0, 5'd15};
    rows[17] = '{enc_i(12'h001, 5'd15, 3'd0, 5'd15), ROW_ALU, 3'd0, 1'b0, 5'd15};
    rows[18] = '{enc_r(7'h00, 5'd4, 5'd15, 3'd7, 5'd16), ROW_ALU, 3'd7, 1'b0, 5'd16};
    rows[19] = '{enc_i(12'h000, 5'd0, 3'd0, 5'd0), ROW_ALU, 3'd0, 1'b0, 5'd0};  // NOP
    rows[20] = '{32'h00100073, ROW_HALT, 3'd0, 1'b0, 5'd0};  // EBREAK
    // Second run after a new reset
    rows[21] = '{enc_u(20'habcde, 5'd20), ROW_ALU, 3'd0, 1'b0, 5'd20};
    rows[22] = '{enc_i(12'h005, 5'd20, 3'd0, 5'd21), ROW_ALU, 3'd0, 1'b0, 5'd21};
    rows[23] = '{32'h00002083, ROW_ILLEGAL, 3'd0, 1'b0, 5'd0};  // LW, unsupported
endtask

`endif

// ==== dv/decode_tb.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_tb;
    import decode_pkg::*;

    typedef enum logic [1:0] {ROW_ALU, ROW_HALT, ROW_ILLEGAL} row_kind_t;
    typedef struct packed {
        inst_t     inst;
        row_kind_t kind;
        alu_op_t   op;
        logic      alt;
        reg_addr_t rd;
    } row_t;
    typedef struct packed {
        alu_op_t   op;
        logic      alt;
        reg_addr_t rd;
        xlen_t     a;
        xlen_t     b;
    } exp_t;

    logic clk, rst, inst_valid, inst_ready, exec_valid, exec_ready, exec_alt;
    logic wb_valid, faulted, finished;
    inst_t inst_data;
    xlen_t inst_pc, exec_rs1_value, exec_rs2_value, wb_value;
    alu_op_t exec_op;
    reg_addr_t exec_rd, wb_addr;
    retire_count_t retired;

    xlen_t shadow [`DECODE_NUM_REGS];
    exp_t exp_q [$];
    exp_t held;
    logic held_valid;
    reg_addr_t ring_rd [64];
    xlen_t ring_val [64];
    int ring_head, ring_tail;  // Head moves on negedge and tail on posedge
    int wb_wait, cur, alu_rows;
    logic [31:0] lfsr;

    function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    alu_op_t f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, alu_op_t f3,
                                    reg_addr_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    `include "decode_tb_table.svh"

    decode_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    endtask

    function automatic xlen_t ref_alu(alu_op_t op, logic alt, xlen_t a, xlen_t b);
        case (op)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Execute unit model driving exec_ready and writeback
    initial begin
        int r;
        lfsr = 32'h4a38688c;
        exec_ready = 1'b0;
        wb_valid = 1'b0;
        wb_addr = '0;
        wb_value = '0;
        wb_wait = 0;
        ring_head = 0;
        forever begin
            @(negedge clk);
            wb_valid = 1'b0;
            if (wb_wait > 0) begin
                wb_wait--;
            end else if (ring_head != ring_tail) begin
                wb_valid = 1'b1;
                wb_addr = ring_rd[ring_head % 64];
                wb_value = ring_val[ring_head % 64];
                ring_head++;
                draw_bits(3, wb_wait);
            end
            draw_bits(2, r);
            exec_ready = (r != 0);  // Low a quarter of the time
        end
    end

    // Monitor on the rising edge sees the pre-edge values
    initial ring_tail = 0;
    always @(posedge clk) begin
        row_t r;
        exp_t e;
        xlen_t res;
        if (rst) begin
            foreach (shadow[i]) shadow[i] = '0;
            exp_q.delete();
            alu_rows = 0;
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                check(exec_valid, 1'b1, "exec_valid under back-pressure");
                check({exec_op, exec_alt, exec_rd}, {held.op, held.alt, held.rd}, "held fields");
                check(exec_rs1_value, held.a, "held rs1 value");
                check(exec_rs2_value, held.b, "held rs2 value");
            end
            held_valid = exec_valid && !exec_ready;
            held = {exec_op, exec_alt, exec_rd, exec_rs1_value, exec_rs2_value};
            if (exec_valid && exec_ready) begin
                if (exp_q.size() == 0) begin
                    check(1'b1, 1'b0, "unexpected execute operation");
                end
                e = exp_q.pop_front();
                check(exec_op, e.op, "exec_op");
                check(exec_alt, e.alt, "exec_alt");
                check(exec_rd, e.rd, "exec_rd");
                check(exec_rs1_value, e.a, "exec_rs1_value");
                check(exec_rs2_value, e.b, "exec_rs2_value");
                res = ref_alu(exec_op, exec_alt, exec_rs1_value, exec_rs2_value);
                ring_rd[ring_tail % 64] = exec_rd;
                ring_val[ring_tail % 64] = res;
                ring_tail++;
            end
            if (inst_valid && inst_ready) begin
                r = rows[cur];
                if (r.kind == ROW_ALU) alu_rows++;
                if (r.kind == ROW_ALU && r.rd != '0) begin
                    e.op = r.op;
                    e.alt = r.alt;
                    e.rd = r.rd;
                    e.a = (r.inst[6:0] == 7'b0110111) ? '0 : shadow[r.inst[19:15]];
                    case (r.inst[6:0])
                        7'b0110011: e.b = shadow[r.inst[24:20]];
                        7'b0010011: e.b = {{20{r.inst[31]}}, r.inst[31:20]};
                        default:    e.b = {r.inst[31:12], 12'b0};
                    endcase
                    exp_q.push_back(e);
                end
            end
            if (wb_valid && wb_addr != '0) shadow[wb_addr] = wb_value;
        end
    end

    task automatic apply_reset();
        int t;
        @(negedge clk);
        rst = 1'b1;
        inst_valid = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        t = 0;
        while (!inst_ready) begin
            @(posedge clk);
            check(faulted, 1'b0, "faulted during clear");
            check(finished, 1'b0, "finished during clear");
            check(exec_valid, 1'b0, "exec_valid during clear");
            check(retired, '0, "retired during clear");
            t++;
            if (t > 100) timeout_fail("register clear");
        end
        if (t < `DECODE_NUM_REGS) check(t, `DECODE_NUM_REGS, "clear cycles");
    endtask

    task automatic present_row(input int i);
        int t;
        @(negedge clk);
        cur = i;
        inst_valid = 1'b1;
        inst_data = rows[i].inst;
        inst_pc = 32'h100 + 4 * i;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > 200) timeout_fail("instruction accept");
        end while (!(inst_valid && inst_ready));
    endtask

    task automatic wait_finished(input logic fault);
        int t;
        @(negedge clk);
        inst_valid = 1'b0;
        t = 0;
        do begin
            @(posedge clk);
            if (!fault) check(faulted, 1'b0, "faulted after halt");
            t++;
            if (t > 300) timeout_fail("finished");
        end while (!finished);
        check(ring_head, ring_tail, "writebacks outstanding at finished");
        check(exp_q.size(), 0, "operations missing at finished");
        check(exec_valid, 1'b0, "exec_valid at finished");
        check(faulted, fault, "faulted");
        check(retired, alu_rows, "retired");
    endtask

    initial begin
        logic need_reset;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst_data = '0;
        inst_pc = '0;
        cur = 0;
        fill_table();
        apply_reset();
        need_reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (need_reset) apply_reset();
            need_reset = 1'b0;
            present_row(i);
            if (rows[i].kind != ROW_ALU) begin
                wait_finished(rows[i].kind == ROW_ILLEGAL);
                need_reset = 1'b1;
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== verilog/decode_top.sv ====
`timescale 1ns/1ps

module decode_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid,
    output logic                      inst_ready,
    input  decode_pkg::inst_t         inst_data,
    input  decode_pkg::xlen_t         inst_pc,
    output logic                      exec_valid,
    input  logic                      exec_ready,
    output decode_pkg::alu_op_t       exec_op,
    output logic                      exec_alt,
    output decode_pkg::xlen_t         exec_rs1_value,
    output decode_pkg::xlen_t         exec_rs2_value,
    output decode_pkg::reg_addr_t     exec_rd,
    input  logic                      wb_valid,
    input  decode_pkg::reg_addr_t     wb_addr,
    input  decode_pkg::xlen_t         wb_value,
    output decode_pkg::retire_count_t retired,
    output logic                      faulted,
    output logic                      finished
);
    import decode_pkg::*;

    reg_addr_t   f_rd;
    reg_addr_t   f_rs1;
    reg_addr_t   f_rs2;
    alu_op_t     f_op;
    logic        f_alt;
    xlen_t       f_imm;
    inst_class_t f_cls;
    logic        f_uses_rs1;
    logic        f_uses_rs2;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    logic        init_done;
    logic        all_clear;

    sb_if sb_bus ();

    inst_fields fields_i (
        .inst     (inst_data),
        .rd       (f_rd),
        .rs1      (f_rs1),
        .rs2      (f_rs2),
        .op       (f_op),
        .alt      (f_alt),
        .imm      (f_imm),
        .cls      (f_cls),
        .uses_rs1 (f_uses_rs1),
        .uses_rs2 (f_uses_rs2)
    );

    // Read ports follow the raw source fields, the controller masks them
    reg_file rf_i (
        .clk, .rst,
        .rd_addr0 (f_rs1),
        .rd_addr1 (f_rs2),
        .wb_valid, .wb_addr, .wb_value,
        .rd_data0 (rs1_data),
        .rd_data1 (rs2_data),
        .init_done
    );

    scoreboard sb_i (
        .clk, .rst,
        .sb       (sb_bus),
        .wb_valid, .wb_addr,
        .all_clear
    );

    issue_ctrl ctrl_i (
        .clk, .rst, .init_done,
        .inst_valid, .inst_pc,
        .rd (f_rd), .rs1 (f_rs1), .rs2 (f_rs2),
        .op (f_op), .alt (f_alt), .imm (f_imm), .cls (f_cls),
        .uses_rs1 (f_uses_rs1), .uses_rs2 (f_uses_rs2),
        .rd_data0 (rs1_data), .rd_data1 (rs2_data),
        .exec_ready, .all_clear,
        .sb (sb_bus),
        .inst_ready, .exec_valid, .exec_op, .exec_alt,
        .exec_rs1_value, .exec_rs2_value, .exec_rd,
        .retired, .faulted, .finished
    );

endmodule

// ==== verilog/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      init_done,
    input  logic                      inst_valid,
    input  decode_pkg::xlen_t         inst_pc,
    input  decode_pkg::reg_addr_t     rd,
    input  decode_pkg::reg_addr_t     rs1,
    input  decode_pkg::reg_addr_t     rs2,
    input  decode_pkg::alu_op_t       op,
    input  logic                      alt,
    input  decode_pkg::xlen_t         imm,
    input  decode_pkg::inst_class_t   cls,
    input  logic                      uses_rs1,
    input  logic                      uses_rs2,
    input  decode_pkg::xlen_t         rd_data0,
    input  decode_pkg::xlen_t         rd_data1,
    input  logic                      exec_ready,
    input  logic                      all_clear,
    sb_if.issue_mp                    sb,
    output logic                      inst_ready,
    output logic                      exec_valid,
    output decode_pkg::alu_op_t       exec_op,
    output logic                      exec_alt,
    output decode_pkg::xlen_t         exec_rs1_value,
    output decode_pkg::xlen_t         exec_rs2_value,
    output decode_pkg::reg_addr_t     exec_rd,
    output decode_pkg::retire_count_t retired,
    output logic                      faulted,
    output logic                      finished
);
    import decode_pkg::*;

    issue_state_t state;
    inst_class_t  eff_cls;
    logic         is_alu;
    logic         sends;     // Produces an execute operation
    logic         out_free;  // Output register can take a new operation
    logic         accept;
    logic         issue_op;

    // A misaligned fetch address faults the same way as an unknown opcode
    assign eff_cls  = (inst_pc[1:0] != 2'b00) ? CLS_ILLEGAL : cls;
    assign is_alu   = (eff_cls == CLS_ALU);
    assign sends    = is_alu && (rd != '0);
    assign out_free = !exec_valid || exec_ready;

    assign inst_ready = (state == ST_RUN) && sb.ready && (out_free || !sends);
    assign accept     = inst_valid && inst_ready;
    assign issue_op   = accept && sends;

    // Sources not read go out as x0, which never stalls
    assign sb.rs1   = (is_alu && uses_rs1) ? rs1 : '0;
    assign sb.rs2   = (is_alu && uses_rs2) ? rs2 : '0;
    assign sb.rd    = is_alu ? rd : '0;
    assign sb.issue = issue_op;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_INIT;
        end else begin
            case (state)
                ST_INIT: begin
                    if (init_done) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (accept && eff_cls == CLS_HALT) begin
                        state <= ST_HALT;
                    end else if (accept && eff_cls == CLS_ILLEGAL) begin
                        state <= ST_FAULT;
                    end
                end
                default: state <= state;  // HALT and FAULT wait for reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_valid <= 1'b0;
            retired    <= '0;
        end else begin
            if (issue_op) begin
                exec_valid <= 1'b1;
            end else if (exec_ready) begin
                exec_valid <= 1'b0;
            end
            // x0 targets retire here without reaching execute
            if (accept && is_alu) begin
                retired <= retired + 1'b1;
            end
        end
    end

    // Loaded only when the slot is free, so fields hold under back-pressure
    always_ff @(posedge clk) begin
        if (issue_op) begin
            exec_op        <= op;
            exec_alt       <= alt;
            exec_rs1_value <= uses_rs1 ? rd_data0 : '0;  // LUI adds to zero
            exec_rs2_value <= uses_rs2 ? rd_data1 : imm;
            exec_rd        <= rd;
        end
    end

    assign faulted  = (state == ST_FAULT);
    assign finished = ((state == ST_HALT) || (state == ST_FAULT)) && all_clear;

endmodule

// ==== verilog/scoreboard.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module scoreboard (
    input  logic                  clk,
    input  logic                  rst,
    sb_if.scoreboard_mp           sb,
    input  logic                  wb_valid,
    input  decode_pkg::reg_addr_t wb_addr,
    output logic                  all_clear
);
    import decode_pkg::*;

    reg_status_t status [`DECODE_NUM_REGS];
    logic        rs1_ok;
    logic        rs2_ok;
    logic        rd_ok;

    // Issue counts up, writeback counts down, both at once cancel
    function automatic reg_status_t step_status(
        input reg_status_t cur,
        input logic        up,
        input logic        down
    );
        reg_status_t nxt;
        nxt = cur;
        if (up && !down) begin
            case (cur)
                REG_VALID: nxt = REG_PEND1;
                REG_PEND1: nxt = REG_PEND2;
                default:   nxt = cur;  // rd check keeps issue away from PEND2
            endcase
        end else if (down && !up) begin
            case (cur)
                REG_PEND2: nxt = REG_PEND1;
                REG_PEND1: nxt = REG_VALID;
                default:   nxt = cur;
            endcase
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DECODE_NUM_REGS; i++) begin
                status[i] <= REG_VALID;
            end
        end else begin
            // Entry 0 is never touched, x0 reads as valid
            for (int i = 1; i < `DECODE_NUM_REGS; i++) begin
                status[i] <= step_status(status[i],
                                         sb.issue && (sb.rd == reg_addr_t'(i)),
                                         wb_valid && (wb_addr == reg_addr_t'(i)));
            end
        end
    end

    assign rs1_ok = (status[sb.rs1] == REG_VALID);
    assign rs2_ok = (status[sb.rs2] == REG_VALID);
    // Room for one more result in flight
    assign rd_ok  = (status[sb.rd] == REG_VALID) || (status[sb.rd] == REG_PEND1);

    assign sb.ready = rs1_ok && rs2_ok && rd_ok;

    always_comb begin
        all_clear = 1'b1;
        for (int i = 0; i < `DECODE_NUM_REGS; i++) begin
            all_clear = all_clear && (status[i] == REG_VALID);
        end
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  decode_pkg::reg_addr_t rd_addr0,
    input  decode_pkg::reg_addr_t rd_addr1,
    input  logic                  wb_valid,
    input  decode_pkg::reg_addr_t wb_addr,
    input  decode_pkg::xlen_t     wb_value,
    output decode_pkg::xlen_t     rd_data0,
    output decode_pkg::xlen_t     rd_data1,
    output logic                  init_done
);
    import decode_pkg::*;

    localparam reg_addr_t LAST_REG = reg_addr_t'(`DECODE_NUM_REGS - 1);

    xlen_t     regs [`DECODE_NUM_REGS];
    reg_addr_t clr_addr;  // Next register to zero
    logic      wr_en;
    reg_addr_t wr_addr;
    xlen_t     wr_data;

    // One register cleared per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_addr  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == LAST_REG) begin
                init_done <= 1'b1;
            end
        end
    end

    // Clear sequence owns the write port until done
    always_comb begin
        if (!init_done) begin
            wr_en   = 1'b1;
            wr_addr = clr_addr;
            wr_data = '0;
        end else begin
            wr_en   = wb_valid && (wb_addr != '0);  // x0 stays zero
            wr_addr = wb_addr;
            wr_data = wb_value;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data0 = regs[rd_addr0];
    assign rd_data1 = regs[rd_addr1];

endmodule

// ==== verilog/inst_fields.sv ====
`timescale 1ns/1ps

module inst_fields (
    input  decode_pkg::inst_t       inst,
    output decode_pkg::reg_addr_t   rd,
    output decode_pkg::reg_addr_t   rs1,
    output decode_pkg::reg_addr_t   rs2,
    output decode_pkg::alu_op_t     op,
    output logic                    alt,
    output decode_pkg::xlen_t       imm,
    output decode_pkg::inst_class_t cls,
    output logic                    uses_rs1,
    output logic                    uses_rs2
);
    import decode_pkg::*;

    localparam alu_op_t     FUNCT3_ADD     = 3'b000;
    localparam alu_op_t     FUNCT3_SRL_SRA = 3'b101;
    localparam alu_op_t     FUNCT3_PRIV    = 3'b000;
    localparam logic [6:0]  FUNCT7_ALT     = 7'b0100000;
    localparam logic [11:0] FUNCT12_EBREAK = 12'h001;

    alu_op_t     funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    xlen_t       i_imm;
    xlen_t       u_imm;

    assign rd      = inst[11:7];
    assign rs1     = inst[19:15];
    assign rs2     = inst[24:20];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign funct12 = inst[31:20];

    assign i_imm = {{20{inst[31]}}, inst[31:20]};  // Sign extended
    assign u_imm = {inst[31:12], 12'b0};

    always_comb begin
        cls      = CLS_ILLEGAL;
        op       = funct3;
        alt      = 1'b0;
        imm      = i_imm;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode_t'(inst[6:0]))
            OPCODE_OP: begin
                cls      = CLS_ALU;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                alt      = (funct7 == FUNCT7_ALT);  // SUB, SRA
            end
            OPCODE_OP_IMM: begin
                cls      = CLS_ALU;
                uses_rs1 = 1'b1;
                // Upper imm bits are shamt space only for shifts, SRAI alone is alt
                alt      = (funct7 == FUNCT7_ALT) && (funct3 == FUNCT3_SRL_SRA);
            end
            OPCODE_LUI: begin
                cls = CLS_ALU;
                op  = FUNCT3_ADD;  // funct3 bits belong to the immediate
                imm = u_imm;
            end
            OPCODE_SYSTEM: begin
                if (funct3 == FUNCT3_PRIV && funct12 == FUNCT12_EBREAK) begin
                    cls = CLS_HALT;
                end
            end
            default: cls = CLS_ILLEGAL;
        endcase
    end

endmodule

// ==== verilog/sb_if.sv ====
`timescale 1ns/1ps

interface sb_if;
    import decode_pkg::*;

    reg_addr_t rs1;    // x0 when the source is not read
    reg_addr_t rs2;
    reg_addr_t rd;     // x0 when nothing is written
    logic      issue;  // Strobe, nonzero rd goes out on this edge
    logic      ready;

    modport issue_mp (
        output rs1,
        output rs2,
        output rd,
        output issue,
        input  ready
    );

    modport scoreboard_mp (
        input  rs1,
        input  rs2,
        input  rd,
        input  issue,
        output ready
    );

endinterface

// ==== verilog/decode_pkg.sv ====
`include "decode_config.svh"

package decode_pkg;

    typedef logic [`DECODE_XLEN-1:0]       xlen_t;
    typedef logic [`DECODE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]                   inst_t;     // Always 32 bits in RV32I
    typedef logic [2:0]                    alu_op_t;   // funct3 of OP / OP-IMM
    typedef logic [`DECODE_RETIRE_W-1:0]   retire_count_t;

    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [1:0] {
        CLS_ALU     = 2'd0,
        CLS_HALT    = 2'd1,
        CLS_ILLEGAL = 2'd2
    } inst_class_t;

    // Number of results still owed to a register
    typedef enum logic [1:0] {
        REG_VALID = 2'd0,
        REG_PEND1 = 2'd1,
        REG_PEND2 = 2'd2
    } reg_status_t;

    typedef enum logic [1:0] {
        ST_INIT  = 2'd0,
        ST_RUN   = 2'd1,
        ST_HALT  = 2'd2,
        ST_FAULT = 2'd3
    } issue_state_t;

endpackage

// ==== verilog/decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Register width and register file geometry, fixed by RV32I
`define DECODE_XLEN        32
`define DECODE_NUM_REGS    32
`define DECODE_REG_ADDR_W  5

// Retired instruction counter, wraps on overflow
`define DECODE_RETIRE_W    16

`endif
